// File: logic/sd_fifo_pkg.sv
// sd_fifo package: depth, word width and pointer types shared by the sync FIFO blocks
package sd_fifo_pkg;

  // --------------------------------------------------
  // sizing
  // --------------------------------------------------

  // number of stored words, must stay a power of two
  localparam int fifo_depth = 16;

  // address width into the word memory
  localparam int fifo_asz = $clog2(fifo_depth);

  // width of one stored word
  localparam int data_width = 8;

  // --------------------------------------------------
  // types
  // --------------------------------------------------

  // payload word as stored in the memory
  typedef logic [data_width-1:0] data_t;

  // memory address, pointer without the wrap flag
  typedef logic [fifo_asz-1:0] addr_t;

  // pointer with wrap flag on top, tells full from empty
  typedef logic [fifo_asz:0] ptr_t;

  // fill count, 0 up to fifo_depth inclusive
  typedef logic [fifo_asz:0] usage_t;

endpackage

// File: logic/sd_fifo_mem_if.sv
// sd_fifo_mem_if: write and read port bundle between head, tail and word memory
interface sd_fifo_mem_if
  import sd_fifo_pkg::*;
();

  // write port, owned by the head
  logic  wr_en;
  addr_t wr_addr;
  data_t wr_data;

  // read request, owned by the tail
  logic  rd_en;
  addr_t rd_addr;

  // registered read data from the memory
  data_t rd_data;

  // head side drives the write port only
  modport head_mp (output wr_en, output wr_addr, output wr_data);

  // tail side issues the read-ahead requests
  modport tail_mp (output rd_en, output rd_addr);

  // memory sees every request and returns the word
  modport mem_mp (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

// File: logic/sd_fifo_head_s.sv
// sd_fifo_head_s: write side of the sync FIFO, accepts consumer words and tracks fill
module sd_fifo_head_s
  import sd_fifo_pkg::*;
(
  input  logic           clk,
  input  logic           clken,
  input  logic           reset,

  // consumer port, word moves on c_srdy & c_drdy
  input  logic           c_srdy,
  output logic           c_drdy,
  input  data_t          c_data,

  // pointer exchange with the tail
  input  ptr_t           rdptr_tail,
  output ptr_t           wrptr_head,

  output usage_t         c_usage,

  sd_fifo_mem_if.head_mp mem
);

  // current write pointer, wrap flag in the top bit
  ptr_t wrptr;
  ptr_t nxt_wrptr;

  logic full;
  logic wr_take;

  // --------------------------------------------------
  // full detection and handshake
  // --------------------------------------------------

  // same slot but different lap means every slot holds a word
  assign full = (wrptr[fifo_asz] != rdptr_tail[fifo_asz]) &&
                (wrptr[fifo_asz-1:0] == rdptr_tail[fifo_asz-1:0]);

  // ready straight from the registered pointers
  assign c_drdy = ~full;

  // a frozen clock enable blocks the transfer entirely
  assign wr_take = clken & c_srdy & c_drdy;

  // --------------------------------------------------
  // write pointer
  // --------------------------------------------------

  // natural rollover of the extra bit flips the wrap flag
  assign nxt_wrptr = wrptr + ptr_t'(1);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wrptr <= '0;
    end
    else if (wr_take)
    begin
      wrptr <= nxt_wrptr;
    end
  end

  // tail compares against this to find waiting words
  assign wrptr_head = wrptr;

  // --------------------------------------------------
  // memory write port
  // --------------------------------------------------

  // word lands in the slot the pointer names now
  assign mem.wr_en   = wr_take;
  assign mem.wr_addr = wrptr[fifo_asz-1:0];
  assign mem.wr_data = c_data;

  // modulo difference of the two pointers gives 0..fifo_depth
  assign c_usage = usage_t'(wrptr - rdptr_tail);

endmodule

// File: logic/sd_fifo_tail_s.sv
// sd_fifo_tail_s: read side of the sync FIFO, read-ahead into a registered producer port
module sd_fifo_tail_s
  import sd_fifo_pkg::*;
(
  input  logic           clk,
  input  logic           clken,
  input  logic           reset,

  // pointer exchange with the head
  input  ptr_t           wrptr_head,
  output ptr_t           rdptr_tail,

  // producer port, data itself comes from the memory register
  output logic           p_srdy,
  input  logic           p_drdy,

  output usage_t         p_usage,

  sd_fifo_mem_if.tail_mp mem
);

  // read pointer of the word currently presented
  ptr_t rdptr;
  ptr_t rdptr_p1;
  ptr_t nxt_rdptr;

  // word available after the coming edge
  logic nxt_p_srdy;

  // presented word held by the destination
  logic stalled;

  // --------------------------------------------------
  // next pointer and read-ahead
  // --------------------------------------------------

  always_comb
  begin
    rdptr_p1 = rdptr + ptr_t'(1);

    // step past the word that leaves in this cycle
    if (p_srdy & p_drdy)
    begin
      nxt_rdptr = rdptr_p1;
    end
    else
    begin
      nxt_rdptr = rdptr;
    end

    // anything written beyond the next read position is valid
    nxt_p_srdy = (wrptr_head != nxt_rdptr);
  end

  // a word on the output that is not taken must stay in the register
  assign stalled = p_srdy & ~p_drdy;

  // fetch the next word so it is present right after the pop edge
  assign mem.rd_en   = clken & nxt_p_srdy & ~stalled;
  assign mem.rd_addr = nxt_rdptr[fifo_asz-1:0];

  // --------------------------------------------------
  // registered state
  // --------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rdptr  <= '0;
      p_srdy <= 1'b0;
    end
    else if (clken)
    begin
      rdptr  <= nxt_rdptr;
      p_srdy <= nxt_p_srdy;
    end
  end

  assign rdptr_tail = rdptr;

  // --------------------------------------------------
  // usage
  // --------------------------------------------------

  always_comb
  begin
    // same lap, plain difference
    if (wrptr_head[fifo_asz] == rdptr[fifo_asz])
    begin
      p_usage = usage_t'(wrptr_head - rdptr);
    end
    // writer one lap ahead, unfold the address bits
    else
    begin
      p_usage = usage_t'({1'b0, wrptr_head[fifo_asz-1:0]}) + usage_t'(fifo_depth)
              - usage_t'({1'b0, rdptr[fifo_asz-1:0]});
    end
  end

endmodule

// File: logic/sd_fifo_mem.sv
// sd_fifo_mem: flop-based dual-port word store with synchronous write and registered read
module sd_fifo_mem
  import sd_fifo_pkg::*;
(
  input  logic          clk,
  sd_fifo_mem_if.mem_mp mem
);

  // --------------------------------------------------
  // storage
  // --------------------------------------------------

  // one data_t per FIFO slot
  data_t mem_array [fifo_depth];

  // write port
  always_ff @(posedge clk)
  begin
    if (mem.wr_en)
    begin
      mem_array[mem.wr_addr] <= mem.wr_data;
    end
  end

  // --------------------------------------------------
  // read port
  // --------------------------------------------------

  // output register doubles as the producer data register,
  // so it keeps its value unless a new word is fetched
  always_ff @(posedge clk)
  begin
    if (mem.rd_en)
    begin
      mem.rd_data <= mem_array[mem.rd_addr];
    end
  end

  // the tail never reads a slot that is written in the same cycle,
  // its read address always trails the write pointer

endmodule

// File: logic/sd_fifo_s.sv
// sd_fifo_s: single-clock srdy/drdy FIFO built from head, word memory and tail
module sd_fifo_s
  import sd_fifo_pkg::*;
(
  input  logic   clk,
  input  logic   clken,
  input  logic   reset,

  // consumer side, words enter here
  input  logic   c_srdy,
  output logic   c_drdy,
  input  data_t  c_data,

  // producer side, words leave here
  output logic   p_srdy,
  input  logic   p_drdy,
  output data_t  p_data,

  // fill level as each side sees it
  output usage_t c_usage,
  output usage_t p_usage
);

  // --------------------------------------------------
  // internal connections
  // --------------------------------------------------

  // pointers crossing between head and tail
  ptr_t wrptr_head;
  ptr_t rdptr_tail;

  // memory port bundle
  sd_fifo_mem_if mem_if ();

  // --------------------------------------------------
  // write side
  // --------------------------------------------------

  sd_fifo_head_s head
  (
    .clk        (clk),
    .clken      (clken),
    .reset      (reset),
    .c_srdy     (c_srdy),
    .c_drdy     (c_drdy),
    .c_data     (c_data),
    .rdptr_tail (rdptr_tail),
    .wrptr_head (wrptr_head),
    .c_usage    (c_usage),
    .mem        (mem_if.head_mp)
  );

  // --------------------------------------------------
  // word store
  // --------------------------------------------------

  sd_fifo_mem mem
  (
    .clk (clk),
    .mem (mem_if.mem_mp)
  );

  // --------------------------------------------------
  // read side
  // --------------------------------------------------

  sd_fifo_tail_s tail
  (
    .clk        (clk),
    .clken      (clken),
    .reset      (reset),
    .wrptr_head (wrptr_head),
    .rdptr_tail (rdptr_tail),
    .p_srdy     (p_srdy),
    .p_drdy     (p_drdy),
    .p_usage    (p_usage),
    .mem        (mem_if.tail_mp)
  );

  // registered read data is the output word, valid with p_srdy
  assign p_data = mem_if.rd_data;

endmodule

// File: sim/sd_fifo_s_asserts.sv
// sd_fifo_s_asserts: concurrent checks on the sync FIFO handshakes, bound into the top level
module sd_fifo_s_asserts
  import sd_fifo_pkg::*;
(
  input logic   clk,
  input logic   reset,
  input logic   c_drdy,
  input logic   p_srdy,
  input logic   p_drdy,
  input data_t  p_data,
  input usage_t c_usage
);

  // --------------------------------------------------
  // reset values
  // --------------------------------------------------

  // empty and ready to accept right out of reset
  a_reset_state : assert property (
    @(posedge clk) reset |=> (!p_srdy && c_drdy)
  ) else $error("p_srdy or c_drdy wrong after reset");

  // --------------------------------------------------
  // producer back-pressure
  // --------------------------------------------------

  // presented word stays put until taken
  a_stall_hold : assert property (
    @(posedge clk) disable iff (reset)
    (p_srdy && !p_drdy) |=> (p_srdy && $stable(p_data))
  ) else $error("producer word changed while stalled");

  // --------------------------------------------------
  // consumer flow control
  // --------------------------------------------------

  // only a full FIFO may refuse a word
  a_drdy_full : assert property (
    @(posedge clk) disable iff (reset)
    !c_drdy |-> (c_usage == usage_t'(fifo_depth))
  ) else $error("c_drdy low while the FIFO is not full");

endmodule

bind sd_fifo_s sd_fifo_s_asserts asserts
(
  .clk     (clk),
  .reset   (reset),
  .c_drdy  (c_drdy),
  .p_srdy  (p_srdy),
  .p_drdy  (p_drdy),
  .p_data  (p_data),
  .c_usage (c_usage)
);

// File: sim/sd_fifo_s_tb.sv
// sd_fifo_s_tb: random producer and consumer around the sync FIFO, checked against a queue model
module sd_fifo_s_tb
  import sd_fifo_pkg::*;
();

  // --------------------------------------------------
  // DUT signals
  // --------------------------------------------------

  logic   clk;
  logic   clken;
  logic   reset;
  logic   c_srdy;
  logic   c_drdy;
  data_t  c_data;
  logic   p_srdy;
  logic   p_drdy;
  data_t  p_data;
  usage_t c_usage;
  usage_t p_usage;

  // wait limits in cycles
  localparam int fill_limit  = 4 * fifo_depth;
  localparam int drain_limit = 4 * fifo_depth;
  localparam int start_limit = 8;

  // --------------------------------------------------
  // model and bookkeeping
  // --------------------------------------------------

  // words accepted by the DUT and not yet delivered
  data_t       model_q[$];
  logic        exp_p_srdy;

  // handshake sampled mid-cycle, applied at the next rising edge
  logic        push_s;
  logic        pop_s;
  logic        ce_s;
  data_t       data_s;
  logic        stall_s;
  data_t       held_data;

  int          errors;
  int          checks;
  int          pushes;
  int          pops;
  logic        timed_out;
  logic [31:0] rand_state;

  sd_fifo_s dut
  (
    .clk     (clk),
    .clken   (clken),
    .reset   (reset),
    .c_srdy  (c_srdy),
    .c_drdy  (c_drdy),
    .c_data  (c_data),
    .p_srdy  (p_srdy),
    .p_drdy  (p_drdy),
    .p_data  (p_data),
    .c_usage (c_usage),
    .p_usage (p_usage)
  );

  always #50 clk = ~clk;

  // numerical recipes LCG, one step per call
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------

  task automatic check_data(input string name, input data_t exp, input data_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("ERROR time %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("ERROR time %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_usage(input string name, input usage_t exp, input usage_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("ERROR time %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  // --------------------------------------------------
  // one clock cycle
  // --------------------------------------------------

  // apply the handshake that the edge just completed
  task automatic update_model();
    if (pop_s)
    begin
      void'(model_q.pop_front());
    end
    // p_srdy is registered, a word written at this edge shows one edge later
    if (ce_s)
    begin
      exp_p_srdy = (model_q.size() != 0);
    end
    if (push_s)
    begin
      model_q.push_back(data_s);
    end
  endtask

  // outputs are settled by the falling edge
  task automatic check_outputs();
    check_flag("c_drdy", model_q.size() != fifo_depth, c_drdy);
    check_flag("p_srdy", exp_p_srdy, p_srdy);
    check_usage("c_usage", usage_t'(model_q.size()), c_usage);
    check_usage("p_usage", usage_t'(model_q.size()), p_usage);
    // stalled word must not move
    if (stall_s)
    begin
      check_data("p_data", held_data, p_data);
    end
    if (p_srdy === 1'b1)
    begin
      if (model_q.size() == 0)
      begin
        errors++;
        $display("p_srdy is high at time %0t while the model holds no word", $time);
      end
      else
      begin
        check_data("p_data", model_q[0], p_data);
      end
    end
    push_s    = clken & c_srdy & c_drdy;
    pop_s     = clken & p_srdy & p_drdy;
    ce_s      = clken;
    data_s    = c_data;
    stall_s   = p_srdy & ~(p_drdy & clken);
    held_data = p_data;
    if (push_s)
      pushes++;
    if (pop_s)
      pops++;
  endtask

  task automatic step(input logic cs, input data_t cd, input logic pd, input logic ce);
    @(posedge clk);
    update_model();
    #10;
    c_srdy = cs;
    c_data = cd;
    p_drdy = pd;
    clken  = ce;
    @(negedge clk);
    check_outputs();
  endtask

  // --------------------------------------------------
  // test phases
  // --------------------------------------------------

  // destination stalled, writer keeps pushing until the FIFO is full
  task automatic fill_test();
    int cycles;
    int base;
    base   = pushes;
    cycles = 0;
    while (c_drdy === 1'b1 && cycles < fill_limit)
    begin
      step(1'b1, data_t'(next_rand()), 1'b0, 1'b1);
      cycles++;
    end
    if (c_drdy !== 1'b0)
    begin
      errors++;
      timed_out = 1'b1;
      $display("c_drdy never fell while the FIFO was being filled");
    end
    else
    begin
      check_usage("words accepted", usage_t'(fifo_depth), usage_t'(pushes - base));
      // extra offers must bounce off a full FIFO
      repeat (6)
        step(1'b1, data_t'(next_rand()), 1'b0, 1'b1);
      check_usage("words accepted", usage_t'(fifo_depth), usage_t'(pushes - base));
    end
  endtask

  // no writes, destination ready until the FIFO runs dry
  task automatic drain_test();
    int cycles;
    int base;
    cycles = 0;
    while ((model_q.size() != 0 || p_srdy !== 1'b0) && cycles < drain_limit)
    begin
      step(1'b0, '0, 1'b1, 1'b1);
      cycles++;
    end
    if (model_q.size() != 0 || p_srdy !== 1'b0)
    begin
      errors++;
      timed_out = 1'b1;
      $display("the FIFO did not empty while being drained");
    end
    else
    begin
      base = pops;
      repeat (8)
        step(1'b0, '0, 1'b1, 1'b1);
      check_usage("words popped while empty", '0, usage_t'(pops - base));
    end
  endtask

  // both sides always ready, one word per cycle after the fall-through
  task automatic stream_test();
    int cycles;
    int base;
    cycles = 0;
    while (p_srdy !== 1'b1 && cycles < start_limit)
    begin
      step(1'b1, data_t'(next_rand()), 1'b1, 1'b1);
      cycles++;
    end
    if (p_srdy !== 1'b1)
    begin
      errors++;
      timed_out = 1'b1;
      $display("p_srdy never rose while streaming into an empty FIFO");
    end
    else
    begin
      base = pops;
      repeat (fifo_depth)
        step(1'b1, data_t'(next_rand()), 1'b1, 1'b1);
      check_usage("words streamed", usage_t'(fifo_depth), usage_t'(pops - base));
    end
  endtask

  // bias is the chance out of 256 that a side is ready, clken low about 1 in 8
  task automatic random_phase(input int cycles, input logic [7:0] c_bias,
                              input logic [7:0] p_bias);
    logic [31:0] r;
    logic [31:0] r2;
    for (int i = 0; i < cycles; i++)
    begin
      r  = next_rand();
      r2 = next_rand();
      step(r[31:24] < c_bias, data_t'(r[15:0]), r[23:16] < p_bias, r2[18:16] != 3'd0);
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial
  begin
    clk        = 1'b0;
    reset      = 1'b1;
    clken      = 1'b1;
    c_srdy     = 1'b0;
    c_data     = '0;
    p_drdy     = 1'b0;
    rand_state = 32'h2477_d442;
    exp_p_srdy = 1'b0;
    push_s     = 1'b0;
    pop_s      = 1'b0;
    ce_s       = 1'b0;
    data_s     = '0;
    stall_s    = 1'b0;
    held_data  = '0;
    errors     = 0;
    checks     = 0;
    pushes     = 0;
    pops       = 0;
    timed_out  = 1'b0;

    repeat (10) @(posedge clk);
    #10;
    reset = 1'b0;

    fill_test();
    if (!timed_out)
      drain_test();
    if (!timed_out)
      stream_test();
    if (!timed_out)
      drain_test();
    if (!timed_out)
    begin
      random_phase(300, 8'd128, 8'd128);
      random_phase(300, 8'd220, 8'd60);
      random_phase(300, 8'd60, 8'd220);
      drain_test();
    end

    $display("checks %0d  errors %0d  words in %0d  words out %0d",
             checks, errors, pushes, pops);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: src.f
logic/sd_fifo_pkg.sv
logic/sd_fifo_mem_if.sv
logic/sd_fifo_head_s.sv
logic/sd_fifo_tail_s.sv
logic/sd_fifo_mem.sv
logic/sd_fifo_s.sv
sim/sd_fifo_s_asserts.sv
sim/sd_fifo_s_tb.sv

// File: Makefile
# Verilator build and run for the sync FIFO testbench

VERILATOR ?= verilator
TOP       ?= sd_fifo_s_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_TEXT := Test completed successfully
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard logic/*.sv) $(wildcard sim/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
